//--- src/rv_isa_pkg.sv
package rv_isa_pkg;

    typedef logic [31:0] word_t;     // data and address word
    typedef logic [4:0]  regaddr_t;  // register index
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // base opcodes, bits [1:0] always 2'b11
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    // integer ops
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;  // srl / sra by funct7
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // branches
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // loads and stores share the size encoding
    localparam funct3_t F3_LB   = 3'b000;
    localparam funct3_t F3_LH   = 3'b001;
    localparam funct3_t F3_LW   = 3'b010;
    localparam funct3_t F3_LBU  = 3'b100;
    localparam funct3_t F3_LHU  = 3'b101;
    localparam funct3_t F3_JALR = 3'b000;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;  // sub, sra, srai

    typedef struct packed {
        funct7_t  funct7;
        regaddr_t rs2;
        regaddr_t rs1;
        funct3_t  funct3;
        regaddr_t rd;
        opcode_t  opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;
        regaddr_t    rs1;
        funct3_t     funct3;
        regaddr_t    rd;
        opcode_t     opcode;
    } instr_i_t;

    // upper 12 bits are either funct7 + rs2 or a signed immediate
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    localparam word_t NOP_IR = 32'h0000_0013;  // addi x0, x0, 0
    localparam word_t NOP_PC = 32'hffff_ffff;

endpackage

//--- src/id_pkg.sv
package id_pkg;

    typedef enum logic [1:0] {
        ALU_OP1_X,
        ALU_OP1_RS1,
        ALU_OP1_IMMU
    } alu_op1_sel_t;

    typedef enum logic [2:0] {
        ALU_OP2_X,
        ALU_OP2_RS2,
        ALU_OP2_IMMI,
        ALU_OP2_IMMS,
        ALU_OP2_PC
    } alu_op2_sel_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_mode_t;

    typedef enum logic [1:0] {MA_NONE, MA_LOAD, MA_STORE} ma_mode_t;

    // values follow the load funct3 encoding
    typedef enum logic [2:0] {
        MA_SIZE_B  = 3'b000,
        MA_SIZE_H  = 3'b001,
        MA_SIZE_W  = 3'b010,
        MA_SIZE_BU = 3'b100,
        MA_SIZE_HU = 3'b101
    } ma_size_t;

    typedef enum logic [1:0] {WB_SRC_ALU, WB_SRC_MEM, WB_SRC_PC4} wb_src_t;

    typedef enum logic [1:0] {PC_NEXT, PC_JUMP_REL, PC_JUMP_ABS, PC_BRANCH} pc_mode_t;

    typedef struct packed {
        alu_op1_sel_t alu_op1;
        alu_op2_sel_t alu_op2;
        alu_mode_t    alu_mode;
        ma_mode_t     ma_mode;
        ma_size_t     ma_size;
        wb_src_t      wb_src;
        logic         wb_valid;
        pc_mode_t     pc_mode;
        logic         ra_used;
        logic         rb_used;
        logic         halt;
    } ctrl_word_t;

    // forwarding from ex / ma, ready low means data not computed yet
    typedef struct packed {
        rv_isa_pkg::regaddr_t addr;
        rv_isa_pkg::word_t    data;
        logic                 valid;
        logic                 ready;
    } fwd_port_t;

    typedef struct packed {
        rv_isa_pkg::regaddr_t addr;
        rv_isa_pkg::word_t    data;
        logic                 valid;
    } wb_port_t;

    typedef struct packed {
        logic              valid;
        rv_isa_pkg::word_t addr;
    } jump_t;

    typedef struct packed {
        rv_isa_pkg::word_t pc;
        rv_isa_pkg::word_t ir;
        rv_isa_pkg::word_t alu_op1;
        rv_isa_pkg::word_t alu_op2;
        alu_mode_t         alu_mode;
        ma_mode_t          ma_mode;
        ma_size_t          ma_size;
        rv_isa_pkg::word_t ma_data;   // store data
        wb_src_t           wb_src;
        rv_isa_pkg::word_t wb_data;   // link address
        logic              wb_valid;
        logic              halt;
    } id_ex_t;

    localparam ctrl_word_t NOP_CW = '{
        alu_op1:  ALU_OP1_X,
        alu_op2:  ALU_OP2_X,
        alu_mode: ALU_ADD,
        ma_mode:  MA_NONE,
        ma_size:  MA_SIZE_W,
        wb_src:   WB_SRC_ALU,
        wb_valid: 1'b0,
        pc_mode:  PC_NEXT,
        ra_used:  1'b0,
        rb_used:  1'b0,
        halt:     1'b0
    };

    localparam id_ex_t ID_EX_BUBBLE = '{
        pc:       rv_isa_pkg::NOP_PC,
        ir:       rv_isa_pkg::NOP_IR,
        alu_op1:  '0,
        alu_op2:  '0,
        alu_mode: ALU_ADD,
        ma_mode:  MA_NONE,
        ma_size:  MA_SIZE_W,
        ma_data:  '0,
        wb_src:   WB_SRC_ALU,
        wb_data:  '0,
        wb_valid: 1'b0,
        halt:     1'b0
    };

endpackage

//--- src/id_decoder.sv
module id_decoder (
    input  rv_isa_pkg::instr_u  ir_i,
    output id_pkg::ctrl_word_t  cw_o
);
    import rv_isa_pkg::*;
    import id_pkg::*;

    // shared by OP and OP_IMM, alt selects sub / sra
    function automatic alu_mode_t alu_mode_of(input funct3_t f3, input logic alt);
        alu_mode_t m;
        case (f3)
            F3_ADD:  m = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:  m = ALU_SLL;
            F3_SLT:  m = ALU_SLT;
            F3_SLTU: m = ALU_SLTU;
            F3_XOR:  m = ALU_XOR;
            F3_SR:   m = alt ? ALU_SRA : ALU_SRL;
            F3_OR:   m = ALU_OR;
            default: m = ALU_AND;
        endcase
        return m;
    endfunction

    funct3_t f3;
    funct7_t f7;
    logic    op_legal;
    logic    imm_legal;

    assign f3 = ir_i.r.funct3;
    assign f7 = ir_i.r.funct7;

    // only add/sub and srl/sra have an alternate funct7
    assign op_legal  = (f7 == F7_BASE) || (f7 == F7_ALT && (f3 == F3_ADD || f3 == F3_SR));
    assign imm_legal = (f3 == F3_SLL) ? (f7 == F7_BASE)
                     : (f3 == F3_SR)  ? (f7 == F7_BASE || f7 == F7_ALT)
                     : 1'b1;

    always_comb begin
        cw_o = NOP_CW;
        case (ir_i.r.opcode)
            OPC_OP: if (op_legal) begin
                cw_o.alu_op1  = ALU_OP1_RS1;
                cw_o.alu_op2  = ALU_OP2_RS2;
                cw_o.alu_mode = alu_mode_of(f3, f7[5]);
                cw_o.wb_valid = 1'b1;
                cw_o.ra_used  = 1'b1;
                cw_o.rb_used  = 1'b1;
            end
            OPC_OP_IMM: if (imm_legal) begin
                cw_o.alu_op1  = ALU_OP1_RS1;
                cw_o.alu_op2  = ALU_OP2_IMMI;
                cw_o.alu_mode = alu_mode_of(f3, f3 == F3_SR && f7[5]);  // no subi
                cw_o.wb_valid = 1'b1;
                cw_o.ra_used  = 1'b1;
            end
            OPC_LOAD: if (f3 inside {F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU}) begin
                cw_o.alu_op1  = ALU_OP1_RS1;
                cw_o.alu_op2  = ALU_OP2_IMMI;
                cw_o.ma_mode  = MA_LOAD;
                cw_o.ma_size  = ma_size_t'(f3);
                cw_o.wb_src   = WB_SRC_MEM;
                cw_o.wb_valid = 1'b1;
                cw_o.ra_used  = 1'b1;
            end
            OPC_STORE: if (f3 inside {F3_LB, F3_LH, F3_LW}) begin
                cw_o.alu_op1  = ALU_OP1_RS1;
                cw_o.alu_op2  = ALU_OP2_IMMS;
                cw_o.ma_mode  = MA_STORE;
                cw_o.ma_size  = ma_size_t'(f3);
                cw_o.ra_used  = 1'b1;
                cw_o.rb_used  = 1'b1;
            end
            OPC_BRANCH: if (f3 != 3'b010 && f3 != 3'b011) begin
                cw_o.pc_mode  = PC_BRANCH;
                cw_o.ra_used  = 1'b1;
                cw_o.rb_used  = 1'b1;
            end
            OPC_JAL: begin
                cw_o.pc_mode  = PC_JUMP_REL;
                cw_o.wb_src   = WB_SRC_PC4;
                cw_o.wb_valid = 1'b1;
            end
            OPC_JALR: if (f3 == F3_JALR) begin
                cw_o.pc_mode  = PC_JUMP_ABS;
                cw_o.wb_src   = WB_SRC_PC4;
                cw_o.wb_valid = 1'b1;
                cw_o.ra_used  = 1'b1;
            end
            OPC_LUI: begin
                cw_o.alu_op1  = ALU_OP1_IMMU;  // imm + 0
                cw_o.wb_valid = 1'b1;
            end
            OPC_AUIPC: begin
                cw_o.alu_op1  = ALU_OP1_IMMU;
                cw_o.alu_op2  = ALU_OP2_PC;
                cw_o.wb_valid = 1'b1;
            end
            OPC_SYSTEM: cw_o.halt = 1'b1;  // ecall / ebreak just stop the core
            default: cw_o = NOP_CW;
        endcase
    end

endmodule

//--- src/id_regfile.sv
module id_regfile #(
    parameter int NUM_REGS = 32
) (
    input  logic                 clk_i,
    input  rv_isa_pkg::regaddr_t rd1_addr_i,
    output rv_isa_pkg::word_t    rd1_data_o,
    input  rv_isa_pkg::regaddr_t rd2_addr_i,
    output rv_isa_pkg::word_t    rd2_data_o,
    input  rv_isa_pkg::regaddr_t wr_addr_i,
    input  rv_isa_pkg::word_t    wr_data_i,
    input  logic                 wr_en_i
);
    import rv_isa_pkg::*;

    word_t regs [1:NUM_REGS-1];  // x0 has no storage

    // x0 and anything past the last register read as zero
    function automatic logic in_range(input regaddr_t a);
        return (a != '0) && (int'(a) < NUM_REGS);
    endfunction

    always_comb begin
        rd1_data_o = in_range(rd1_addr_i) ? regs[rd1_addr_i] : '0;
        rd2_data_o = in_range(rd2_addr_i) ? regs[rd2_addr_i] : '0;
    end

    always_ff @(posedge clk_i) begin
        if (wr_en_i && in_range(wr_addr_i)) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

endmodule

//--- src/id_stage.sv
module id_stage #(
    parameter int NUM_REGS = 32
) (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  rv_isa_pkg::word_t     pc_i,
    input  rv_isa_pkg::instr_u    ir_i,
    input  id_pkg::fwd_port_t     ex_fwd_i,
    input  id_pkg::fwd_port_t     ma_fwd_i,
    input  id_pkg::wb_port_t      wb_i,
    output logic                  ready_o,
    output id_pkg::jump_t         jmp_o,
    output id_pkg::id_ex_t        id_ex_o
);
    import rv_isa_pkg::*;
    import id_pkg::*;

    regaddr_t   rs1;
    regaddr_t   rs2;
    word_t      ir_w;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    ctrl_word_t cw;

    assign rs1  = ir_i.r.rs1;
    assign rs2  = ir_i.r.rs2;
    assign ir_w = ir_i;

    always_comb begin
        imm_i = {{20{ir_i.i.imm[11]}}, ir_i.i.imm};  // i view
        imm_s = {{20{ir_w[31]}}, ir_i.r.funct7, ir_i.r.rd};
        imm_b = {{20{ir_w[31]}}, ir_w[7], ir_w[30:25], ir_w[11:8], 1'b0};
        imm_u = {ir_w[31:12], 12'b0};
        imm_j = {{12{ir_w[31]}}, ir_w[19:12], ir_w[20], ir_w[30:21], 1'b0};
    end

    id_decoder u_decoder (
        .ir_i (ir_i),
        .cw_o (cw)
    );

    word_t ra_rf, rb_rf;

    id_regfile #(
        .NUM_REGS (NUM_REGS)
    ) u_regfile (
        .clk_i      (clk_i),
        .rd1_addr_i (rs1),
        .rd1_data_o (ra_rf),
        .rd2_addr_i (rs2),
        .rd2_data_o (rb_rf),
        .wr_addr_i  (wb_i.addr),
        .wr_data_i  (wb_i.data),
        .wr_en_i    (wb_i.valid)
    );

    // port holds a pending result for register a
    function automatic logic pending(input fwd_port_t p, input regaddr_t a);
        return p.valid && !p.ready && p.addr == a && a != '0;
    endfunction

    // youngest producer wins: ex, then ma, then wb, then the array
    function automatic word_t bypass(input fwd_port_t ex, input fwd_port_t ma,
                                     input wb_port_t wb, input regaddr_t a,
                                     input word_t rf);
        word_t d;
        if (a == '0)
            d = '0;
        else if (ex.valid && ex.addr == a)
            d = ex.data;
        else if (ma.valid && ma.addr == a)
            d = ma.data;
        else if (wb.valid && wb.addr == a)
            d = wb.data;  // write lands next edge
        else
            d = rf;
        return d;
    endfunction

    logic  hazard;
    word_t ra, rb;

    always_comb begin
        ra = bypass(ex_fwd_i, ma_fwd_i, wb_i, rs1, ra_rf);
        rb = bypass(ex_fwd_i, ma_fwd_i, wb_i, rs2, rb_rf);
        hazard = (cw.ra_used && (pending(ex_fwd_i, rs1) || pending(ma_fwd_i, rs1)))
              || (cw.rb_used && (pending(ex_fwd_i, rs2) || pending(ma_fwd_i, rs2)));
        ready_o = !hazard;
    end

    word_t op1, op2;

    always_comb begin
        case (cw.alu_op1)
            ALU_OP1_RS1:  op1 = ra;
            ALU_OP1_IMMU: op1 = imm_u;
            default:      op1 = '0;
        endcase
        case (cw.alu_op2)
            ALU_OP2_RS2:  op2 = rb;
            ALU_OP2_IMMI: op2 = imm_i;
            ALU_OP2_IMMS: op2 = imm_s;
            ALU_OP2_PC:   op2 = pc_i;
            default:      op2 = '0;
        endcase
    end

    logic taken;

    always_comb begin
        case (ir_i.r.funct3)
            F3_BEQ:  taken = (ra == rb);
            F3_BNE:  taken = (ra != rb);
            F3_BLT:  taken = ($signed(ra) <  $signed(rb));
            F3_BGE:  taken = ($signed(ra) >= $signed(rb));
            F3_BLTU: taken = (ra <  rb);
            F3_BGEU: taken = (ra >= rb);
            default: taken = 1'b0;
        endcase
    end

    // jal needs no register, so it redirects even while stalled
    always_comb begin
        case (cw.pc_mode)
            PC_JUMP_REL: jmp_o = '{valid: 1'b1, addr: pc_i + imm_j};
            PC_JUMP_ABS: jmp_o = '{valid: !hazard, addr: ra + imm_i};
            PC_BRANCH:   jmp_o = '{valid: taken && !hazard, addr: pc_i + imm_b};
            default:     jmp_o = '{valid: 1'b0, addr: '0};
        endcase
    end

    id_ex_t ex_next;

    always_comb begin
        ex_next.pc       = pc_i;
        ex_next.ir       = ir_w;
        ex_next.alu_op1  = op1;
        ex_next.alu_op2  = op2;
        ex_next.alu_mode = cw.alu_mode;
        ex_next.ma_mode  = cw.ma_mode;
        ex_next.ma_size  = cw.ma_size;
        ex_next.ma_data  = rb;          // store data
        ex_next.wb_src   = cw.wb_src;
        ex_next.wb_data  = pc_i + 32'd4;
        ex_next.wb_valid = cw.wb_valid;
        ex_next.halt     = cw.halt;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            id_ex_o <= ID_EX_BUBBLE;
        end else if (hazard) begin
            id_ex_o <= ID_EX_BUBBLE;  // fetch holds, execute gets a nop
        end else begin
            id_ex_o <= ex_next;
        end
    end

endmodule

//--- tests/id_stage_tb.sv
module id_stage_tb;
    import rv_isa_pkg::*;
    import id_pkg::*;

    localparam int STIM_CYCLES    = 200;  // roughly what the sequence below needs
    localparam int TIMEOUT_CYCLES = 10 * STIM_CYCLES;
    localparam funct3_t BR_F3 [6] = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
    localparam funct3_t LD_F3 [5] = '{F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU};

    // expected combinational outputs, same cycle
    typedef struct packed {
        logic  ready;
        logic  jv;
        logic  chk_ja;
        word_t ja;
    } ctl_exp_t;

    // expected execute bundle, chk_* bits mark fields that matter
    typedef struct packed {
        word_t     pc;
        word_t     ir;
        logic      chk_op1;
        word_t     op1;
        logic      chk_op2;
        word_t     op2;
        alu_mode_t alu_mode;
        ma_mode_t  ma_mode;
        logic      chk_size;
        ma_size_t  ma_size;
        word_t     ma_data;
        wb_src_t   wb_src;
        word_t     wb_data;
        logic      wb_valid;
        logic      halt;
    } ex_exp_t;

    logic      clk_i;
    logic      arst_n_i;
    word_t     pc;
    word_t     ir;
    fwd_port_t ex_fwd;
    fwd_port_t ma_fwd;
    wb_port_t  wb;
    logic      ready;
    jump_t     jmp;
    id_ex_t    id_ex;

    ctl_exp_t exp_c;
    ex_exp_t  exp_n;
    ex_exp_t  exp_q;
    word_t    shadow [32];  // architectural register model
    word_t    cur_pc;
    word_t    seed;
    logic     chk_en;
    int       errors;
    int       cycles;

    id_stage #(
        .NUM_REGS (32)
    ) DUT (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .pc_i     (pc),
        .ir_i     (ir),
        .ex_fwd_i (ex_fwd),
        .ma_fwd_i (ma_fwd),
        .wb_i     (wb),
        .ready_o  (ready),
        .jmp_o    (jmp),
        .id_ex_o  (id_ex)
    );

    always #2 clk_i = ~clk_i;

    function automatic word_t lcg();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    function automatic regaddr_t rnd_reg();
        word_t r;
        r = lcg();
        return r[31:27];  // upper bits are the better ones
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input regaddr_t rs2,
                                    input regaddr_t rs1, input logic [2:0] f3,
                                    input regaddr_t rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_i(input word_t imm, input regaddr_t rs1,
                                    input logic [2:0] f3, input regaddr_t rd,
                                    input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input word_t imm, input regaddr_t rs2,
                                    input regaddr_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t enc_b(input word_t imm, input regaddr_t rs2,
                                    input regaddr_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t enc_j(input word_t imm, input regaddr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // ex beats ma beats wb beats the register array
    function automatic word_t operand(input regaddr_t a);
        word_t d;
        if (a == '0)
            d = '0;
        else if (ex_fwd.valid && ex_fwd.addr == a)
            d = ex_fwd.data;
        else if (ma_fwd.valid && ma_fwd.addr == a)
            d = ma_fwd.data;
        else if (wb.valid && wb.addr == a)
            d = wb.data;
        else
            d = shadow[a];
        return d;
    endfunction

    function automatic logic pending(input regaddr_t a);
        return a != '0 && ((ex_fwd.valid && !ex_fwd.ready && ex_fwd.addr == a)
                        || (ma_fwd.valid && !ma_fwd.ready && ma_fwd.addr == a));
    endfunction

    function automatic ex_exp_t bubble();
        ex_exp_t b;
        b = '0;
        b.pc = NOP_PC;
        b.ir = NOP_IR;
        b.chk_op1 = 1'b1;
        b.chk_op2 = 1'b1;
        b.alu_mode = ALU_ADD;
        b.ma_mode = MA_NONE;
        b.wb_src = WB_SRC_ALU;
        return b;
    endfunction

    task automatic mismatch(input string name, input word_t e, input word_t a);
        errors++;
        $display("Mismatch at time %0t: %s expected %h, got %h", $time, name, e, a);
    endtask

    // falling edge, commit last cycle's write, ports back to idle
    task automatic next_cycle();
        @(negedge clk_i);
        if (wb.valid && wb.addr != '0)
            shadow[wb.addr] = wb.data;
        ex_fwd = '0;
        ma_fwd = '0;
        wb = '0;
    endtask

    // drive one instruction and predict what decode must make of it
    task automatic issue(input word_t instr, input word_t imm);
        logic [6:0] opc;
        logic [2:0] f3;
        regaddr_t   a;
        regaddr_t   b;
        word_t      ra;
        word_t      rb;
        logic       hz;
        logic       take;
        opc = instr[6:0];
        f3  = instr[14:12];
        a   = instr[19:15];
        b   = instr[24:20];
        ra  = operand(a);
        rb  = operand(b);
        hz  = (opc inside {OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_JALR}
               && pending(a))
           || (opc inside {OPC_OP, OPC_STORE, OPC_BRANCH} && pending(b));
        case (f3)
            F3_BEQ:  take = ra == rb;
            F3_BNE:  take = ra != rb;
            F3_BLT:  take = $signed(ra) < $signed(rb);
            F3_BGE:  take = $signed(ra) >= $signed(rb);
            F3_BLTU: take = ra < rb;
            F3_BGEU: take = ra >= rb;
            default: take = 1'b0;
        endcase
        pc = cur_pc;
        ir = instr;
        exp_c = '{ready: !hz, jv: 1'b0, chk_ja: 1'b0, ja: '0};
        // the only alu instructions issued here are add and addi
        exp_n = '{pc: cur_pc, ir: instr, chk_op1: 1'b1, op1: ra, chk_op2: 1'b1, op2: imm,
                  alu_mode: ALU_ADD, ma_mode: MA_NONE, chk_size: 1'b0, ma_size: MA_SIZE_W,
                  ma_data: rb, wb_src: WB_SRC_ALU, wb_data: cur_pc + 32'd4,
                  wb_valid: 1'b1, halt: 1'b0};
        case (opc)
            OPC_OP: exp_n.op2 = rb;
            OPC_LOAD: begin
                exp_n.ma_mode  = MA_LOAD;
                exp_n.wb_src   = WB_SRC_MEM;
                exp_n.chk_size = 1'b1;
                case (f3)
                    F3_LB:   exp_n.ma_size = MA_SIZE_B;
                    F3_LH:   exp_n.ma_size = MA_SIZE_H;
                    F3_LBU:  exp_n.ma_size = MA_SIZE_BU;
                    F3_LHU:  exp_n.ma_size = MA_SIZE_HU;
                    default: exp_n.ma_size = MA_SIZE_W;
                endcase
            end
            OPC_STORE: begin
                exp_n.ma_mode  = MA_STORE;
                exp_n.wb_valid = 1'b0;
            end
            OPC_BRANCH: begin
                exp_c = '{ready: !hz, jv: take && !hz, chk_ja: 1'b1, ja: cur_pc + imm};
                exp_n.wb_valid = 1'b0;
            end
            OPC_JAL:  exp_c = '{ready: 1'b1, jv: 1'b1, chk_ja: 1'b1, ja: cur_pc + imm};
            OPC_JALR: exp_c = '{ready: !hz, jv: !hz, chk_ja: 1'b1, ja: ra + imm};
            OPC_LUI: begin
                exp_n.op1     = imm;
                exp_n.chk_op2 = 1'b0;
            end
            OPC_AUIPC: begin
                exp_n.op1 = imm;
                exp_n.op2 = cur_pc;
            end
            OPC_SYSTEM: begin
                exp_n.halt     = 1'b1;
                exp_n.wb_valid = 1'b0;
                exp_n.chk_op1  = 1'b0;
                exp_n.chk_op2  = 1'b0;
            end
            default: ;
        endcase
        if (opc == OPC_JAL || opc == OPC_JALR)
            exp_n.wb_src = WB_SRC_PC4;  // link register gets pc + 4
        if (exp_c.chk_ja) begin
            exp_n.chk_op1 = 1'b0;  // jumps leave the alu operands open
            exp_n.chk_op2 = 1'b0;
        end
        if (hz)
            exp_n = bubble();
        else
            cur_pc = cur_pc + 32'd4;  // fetch holds pc while stalled
    endtask

    task automatic run_reset();
        int i;
        for (i = 0; i < 16; i++) begin
            next_cycle();
            issue(NOP_IR, '0);
            chk_en = 1'b1;
        end
        arst_n_i = 1'b1;
    endtask

    task automatic fill_registers();
        int r;
        for (r = 1; r < 32; r++) begin
            next_cycle();
            wb = '{addr: regaddr_t'(r), data: lcg(), valid: 1'b1};
            issue(NOP_IR, '0);
        end
    endtask

    task automatic check_regfile_reads();
        int    n;
        word_t r;
        word_t imm;
        for (n = 0; n < 20; n++) begin
            next_cycle();
            issue(enc_r(F7_BASE, rnd_reg(), rnd_reg(), F3_ADD, rnd_reg(), OPC_OP), '0);
            next_cycle();
            r = lcg();
            imm = {{20{r[11]}}, r[11:0]};
            issue(enc_i(imm, rnd_reg(), F3_ADD, rnd_reg(), OPC_OP_IMM), imm);
        end
        next_cycle();
        issue(enc_r(F7_BASE, 5'd0, 5'd0, F3_ADD, 5'd3, OPC_OP), '0);  // x0 both sides
    endtask

    task automatic check_bypass();
        fwd_port_t ex_p;
        fwd_port_t ma_p;
        int        n;
        ex_p = '{addr: 5'd7, data: lcg(), valid: 1'b1, ready: 1'b1};
        ma_p = '{addr: 5'd7, data: lcg(), valid: 1'b1, ready: 1'b1};
        // sources drop out one by one, last pass reads the array
        for (n = 0; n < 4; n++) begin
            next_cycle();
            if (n < 1)
                ex_fwd = ex_p;
            if (n < 2)
                ma_fwd = ma_p;
            if (n < 3)
                wb = '{addr: 5'd7, data: lcg(), valid: 1'b1};  // new value, array is stale
            issue(enc_r(F7_BASE, 5'd7, 5'd7, F3_ADD, 5'd1, OPC_OP), '0);
        end
    endtask

    task automatic check_hazards();
        word_t add_a;
        word_t add_b;
        word_t jalr;
        add_a = enc_r(F7_BASE, 5'd3, 5'd9, F3_ADD, 5'd2, OPC_OP);
        add_b = enc_r(F7_BASE, 5'd3, 5'd1, F3_ADD, 5'd4, OPC_OP);
        jalr  = enc_i(32'h0000_0010, 5'd9, F3_JALR, 5'd1, OPC_JALR);
        next_cycle();
        ex_fwd = '{addr: 5'd9, data: lcg(), valid: 1'b1, ready: 1'b0};
        issue(add_a, '0);
        next_cycle();
        ex_fwd = '{addr: 5'd9, data: lcg(), valid: 1'b1, ready: 1'b1};  // result arrives
        issue(add_a, '0);
        next_cycle();
        ma_fwd = '{addr: 5'd3, data: lcg(), valid: 1'b1, ready: 1'b0};  // rs2 side
        issue(add_b, '0);
        next_cycle();
        issue(add_b, '0);
        next_cycle();
        ex_fwd = '{addr: 5'd9, data: lcg(), valid: 1'b1, ready: 1'b0};
        issue({20'h00048, 5'd5, 7'b0110111}, 32'h0004_8000);  // lui, rs1 field is 9
        next_cycle();
        ex_fwd = '{addr: 5'd9, data: lcg(), valid: 1'b1, ready: 1'b0};
        issue(jalr, 32'h0000_0010);
        next_cycle();
        issue(jalr, 32'h0000_0010);
        next_cycle();
        ex_fwd = '{addr: 5'd12, data: lcg(), valid: 1'b1, ready: 1'b0};
        issue(enc_b(32'h0000_0020, 5'd12, 5'd12, F3_BEQ), 32'h0000_0020);
    endtask

    task automatic check_control_flow();
        int       k;
        int       n;
        regaddr_t a;
        regaddr_t b;
        word_t    r;
        word_t    imm;
        for (k = 0; k < 6; k++) begin
            for (n = 0; n < 4; n++) begin
                next_cycle();
                a = rnd_reg();
                b = (n == 0) ? a : rnd_reg();  // equal operands once per kind
                r = lcg();
                imm = {{19{r[12]}}, r[12:1], 1'b0};
                issue(enc_b(imm, b, a, BR_F3[k]), imm);
            end
        end
        for (n = 0; n < 4; n++) begin
            next_cycle();
            r = lcg();
            imm = {{11{r[20]}}, r[20:1], 1'b0};
            issue(enc_j(imm, 5'd1), imm);
            next_cycle();
            r = lcg();
            imm = {{20{r[11]}}, r[11:0]};
            issue(enc_i(imm, rnd_reg(), F3_JALR, 5'd1, OPC_JALR), imm);
        end
    endtask

    task automatic check_selects();
        int    k;
        word_t r;
        word_t imm;
        next_cycle();
        r = lcg();
        issue({r[31:12], 5'd6, 7'b0110111}, {r[31:12], 12'b0});  // lui
        next_cycle();
        r = lcg();
        issue({r[31:12], 5'd6, 7'b0010111}, {r[31:12], 12'b0});  // auipc
        for (k = 0; k < 5; k++) begin
            next_cycle();
            r = lcg();
            imm = {{20{r[11]}}, r[11:0]};
            issue(enc_i(imm, rnd_reg(), LD_F3[k], 5'd8, OPC_LOAD), imm);
        end
        next_cycle();
        r = lcg();
        imm = {{20{r[11]}}, r[11:0]};
        issue(enc_s(imm, rnd_reg(), rnd_reg(), F3_LW), imm);
        next_cycle();
        issue(32'h0000_0073, '0);  // ecall
    endtask

    // expected bundle moves with the DUT register
    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i)
            exp_q <= bubble();
        else
            exp_q <= exp_n;
    end

    a_ready: assert property (@(posedge clk_i) disable iff (!chk_en) ready == exp_c.ready)
        else mismatch("ready_o", 32'($sampled(exp_c.ready)), 32'($sampled(ready)));
    a_jv: assert property (@(posedge clk_i) disable iff (!chk_en) jmp.valid == exp_c.jv)
        else mismatch("jmp_o.valid", 32'($sampled(exp_c.jv)), 32'($sampled(jmp.valid)));
    a_ja: assert property (@(posedge clk_i) disable iff (!chk_en)
        !exp_c.chk_ja || jmp.addr == exp_c.ja)
        else mismatch("jmp_o.addr", $sampled(exp_c.ja), $sampled(jmp.addr));
    a_pc: assert property (@(posedge clk_i) disable iff (!chk_en) id_ex.pc == exp_q.pc)
        else mismatch("id_ex_o.pc", $sampled(exp_q.pc), $sampled(id_ex.pc));
    a_ir: assert property (@(posedge clk_i) disable iff (!chk_en) id_ex.ir == exp_q.ir)
        else mismatch("id_ex_o.ir", $sampled(exp_q.ir), $sampled(id_ex.ir));
    a_op1: assert property (@(posedge clk_i) disable iff (!chk_en)
        !exp_q.chk_op1 || id_ex.alu_op1 == exp_q.op1)
        else mismatch("id_ex_o.alu_op1", $sampled(exp_q.op1), $sampled(id_ex.alu_op1));
    a_op2: assert property (@(posedge clk_i) disable iff (!chk_en)
        !exp_q.chk_op2 || id_ex.alu_op2 == exp_q.op2)
        else mismatch("id_ex_o.alu_op2", $sampled(exp_q.op2), $sampled(id_ex.alu_op2));
    a_alu_mode: assert property (@(posedge clk_i) disable iff (!chk_en)
        id_ex.alu_mode == exp_q.alu_mode)
        else mismatch("id_ex_o.alu_mode", 32'($sampled(exp_q.alu_mode)),
                      32'($sampled(id_ex.alu_mode)));
    a_ma_mode: assert property (@(posedge clk_i) disable iff (!chk_en)
        id_ex.ma_mode == exp_q.ma_mode)
        else mismatch("id_ex_o.ma_mode", 32'($sampled(exp_q.ma_mode)),
                      32'($sampled(id_ex.ma_mode)));
    a_ma_size: assert property (@(posedge clk_i) disable iff (!chk_en)
        !exp_q.chk_size || id_ex.ma_size == exp_q.ma_size)
        else mismatch("id_ex_o.ma_size", 32'($sampled(exp_q.ma_size)),
                      32'($sampled(id_ex.ma_size)));
    a_ma_data: assert property (@(posedge clk_i) disable iff (!chk_en)
        id_ex.ma_data == exp_q.ma_data)
        else mismatch("id_ex_o.ma_data", $sampled(exp_q.ma_data), $sampled(id_ex.ma_data));
    a_wb_src: assert property (@(posedge clk_i) disable iff (!chk_en)
        id_ex.wb_src == exp_q.wb_src)
        else mismatch("id_ex_o.wb_src", 32'($sampled(exp_q.wb_src)),
                      32'($sampled(id_ex.wb_src)));
    a_wb_data: assert property (@(posedge clk_i) disable iff (!chk_en)
        id_ex.wb_data == exp_q.wb_data)
        else mismatch("id_ex_o.wb_data", $sampled(exp_q.wb_data), $sampled(id_ex.wb_data));
    a_wb_valid: assert property (@(posedge clk_i) disable iff (!chk_en)
        id_ex.wb_valid == exp_q.wb_valid)
        else mismatch("id_ex_o.wb_valid", 32'($sampled(exp_q.wb_valid)),
                      32'($sampled(id_ex.wb_valid)));
    a_halt: assert property (@(posedge clk_i) disable iff (!chk_en) id_ex.halt == exp_q.halt)
        else mismatch("id_ex_o.halt", 32'($sampled(exp_q.halt)), 32'($sampled(id_ex.halt)));

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycles++;
        end
        errors++;
        $display("timeout: stimulus still running after %0d cycles, errors: %0d",
                 TIMEOUT_CYCLES, errors);
        $display("Checks failed");
        $finish;
    end

    initial begin
        errors   = 0;
        seed     = 32'd38200;
        clk_i    = 1'b0;
        arst_n_i = 1'b0;
        chk_en   = 1'b0;
        cur_pc   = 32'h0000_1000;
        pc       = NOP_PC;
        ir       = NOP_IR;
        ex_fwd   = '0;
        ma_fwd   = '0;
        wb       = '0;
        run_reset();
        fill_registers();
        check_regfile_reads();
        check_bypass();
        check_hazards();
        check_control_flow();
        check_selects();
        next_cycle();
        issue(NOP_IR, '0);
        next_cycle();
        issue(NOP_IR, '0);
        next_cycle();  // last bundle compared by now
        $display("cycles run: %0d, errors: %0d", cycles, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
src/rv_isa_pkg.sv
src/id_pkg.sv
src/id_decoder.sv
src/id_regfile.sv
src/id_stage.sv
tests/id_stage_tb.sv

//--- run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module id_stage_tb -f vlog.f -o id_stage_sim
out=$(./obj_dir/id_stage_sim)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
